/* Makefile */
# Verilator build and run for the cartridge loader testbench

VERILATOR ?= verilator
TOP       ?= cart_loader_tb
FILELIST  ?= cart_loader.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) bench/tb_util.svh

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_util.svh */
// Testbench helpers for the cartridge loader bench, included inside the testbench module
`ifndef TB_UTIL_SVH
`define TB_UTIL_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per returned bit
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] bits;
	bits = '0;
	for (int i = 0; i < n; i++) begin
		bits = {bits[30:0], lfsr_state[31]};
		lfsr_state = lfsr_step(lfsr_state);
	end
	return bits;
endfunction

// Header bytes 'h1F0 to 'h1F2 pick the flags, then the order decides
function automatic region_t expected_region(input logic [31:0] letters, input region_order_t ord);
	logic    fj;
	logic    fu;
	logic    fe;
	logic    [7:0] ch;
	region_t pri [3];
	region_t res;
	fj = 1'b0;
	fu = 1'b0;
	fe = 1'b0;
	for (int i = 0; i < 3; i++) begin
		ch = letters[8*(3-i) +: 8];
		if (ch == "J") begin
			fj = 1'b1;
		end else if (ch == "U") begin
			fu = 1'b1;
		end else if (ch >= "0" && ch <= "Z") begin
			fe = 1'b1;
		end
	end
	case (ord)
		ORDER_US_EU_JP: pri = '{US, EU, JP};
		ORDER_EU_US_JP: pri = '{EU, US, JP};
		ORDER_US_JP_EU: pri = '{US, JP, EU};
		default:        pri = '{JP, US, EU};
	endcase
	res = pri[0];
	for (int i = 2; i >= 0; i--) begin
		if ((pri[i] == JP && fj) || (pri[i] == US && fu) || (pri[i] == EU && fe)) begin
			res = pri[i];
		end
	end
	return res;
endfunction

// First table entry that matches wins, '?' accepts any byte
function automatic logic [QUIRK_COUNT-1:0] expected_quirks(input logic [63:0] id);
	logic [QUIRK_COUNT-1:0] q;
	logic                   found;
	logic                   ok;
	q = '0;
	found = 1'b0;
	for (int e = 0; e < QUIRK_TABLE_LEN; e++) begin
		ok = 1'b1;
		for (int b = 0; b < 8; b++) begin
			if (QUIRK_ID[e][8*b +: 8] != "?" && QUIRK_ID[e][8*b +: 8] != id[8*b +: 8]) begin
				ok = 1'b0;
			end
		end
		if (ok && !found) begin
			q[int'(QUIRK_KIND[e])] = 1'b1;
			found = 1'b1;
		end
	end
	return q;
endfunction

task automatic wait_write_done();
	int n;
	n = 0;
	while (rom_wr_req != rom_wr_ack) begin
		@(negedge clk_sys);
		n++;
		if (n > WAIT_LIMIT) begin
			stop_failed("ROM write was never acknowledged");
		end
	end
endtask

task automatic wait_region_set();
	int n;
	n = 0;
	while (!region_set) begin
		@(negedge clk_sys);
		n++;
		if (n > WAIT_LIMIT) begin
			stop_failed("region_set never rose after the header");
		end
	end
endtask

`endif

/* bench/cart_loader_tb.sv */
// Testbench for the cartridge loader: runs full cartridge loads and checks with assertions
`timescale 1ns/1ps
`default_nettype none

module cart_loader_tb
	import cart_pkg::*;
;

	localparam int CLK_HALF   = 4;
	localparam int WAIT_LIMIT = 200;

	logic                   clk_sys;
	logic                   RESET;
	logic                   dl_active;
	logic                   dl_valid;
	logic                   dl_ready;
	logic [ADDR_W-1:0]      dl_addr;
	logic [DATA_W-1:0]      dl_data;
	logic [ADDR_W-2:0]      rom_addr;
	logic [DATA_W-1:0]      rom_wdata;
	logic                   rom_wr_req;
	logic                   rom_wr_ack;
	logic [ADDR_W-1:0]      rom_size;
	logic                   region_auto;
	region_order_t          region_order;
	region_t                region;
	logic                   region_set;
	logic [QUIRK_COUNT-1:0] quirks;

	logic [31:0]            lfsr_state = 32'h35bb;
	logic                   took = 1'b0;
	logic                   req_d = 1'b0;
	logic [ADDR_W-2:0]      exp_addr = '0;
	logic [DATA_W-1:0]      exp_wdata = '0;
	logic [ADDR_W-1:0]      last_size = '0;
	logic                   mem_busy = 1'b0;
	logic [2:0]             mem_wait = '0;
	logic                   region_chk = 1'b0;
	logic                   quirk_chk = 1'b0;
	logic                   size_chk = 1'b0;
	region_t                exp_region = JP;
	logic [QUIRK_COUNT-1:0] exp_q = '0;
	int                     region_checks = 0;
	int                     quirk_checks = 0;

	task automatic stop_failed(input string what);
		$display("%s", what);
		$display("Simulation finished: FAIL");
		$fatal(1);
	endtask

	`include "tb_util.svh"

	cart_loader dut_i (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.dl_active    (dl_active),
		.dl_valid     (dl_valid),
		.dl_ready     (dl_ready),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.rom_addr     (rom_addr),
		.rom_wdata    (rom_wdata),
		.rom_wr_req   (rom_wr_req),
		.rom_wr_ack   (rom_wr_ack),
		.rom_size     (rom_size),
		.region_auto  (region_auto),
		.region_order (region_order),
		.region       (region),
		.region_set   (region_set),
		.quirks       (quirks)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	//////////////////////////////////////////////////////////////////////
	// Transfer tracking and memory model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk_sys) begin
		req_d <= rom_wr_req;
		took  <= dl_valid & dl_ready & ~RESET;
		if (dl_valid && dl_ready) begin
			exp_addr  <= dl_addr[ADDR_W-1:1];
			exp_wdata <= {dl_data[7:0], dl_data[15:8]};
			last_size <= dl_addr;
		end
	end

	// Acknowledge after 0 to 7 cycles
	always @(negedge clk_sys) begin
		if (RESET) begin
			rom_wr_ack = 1'b0;
			mem_busy   = 1'b0;
		end else begin
			if (!mem_busy && rom_wr_req != rom_wr_ack) begin
				mem_wait = 3'(take_bits(3));
				mem_busy = 1'b1;
			end
			if (mem_busy) begin
				if (mem_wait == 3'd0) begin
					rom_wr_ack = rom_wr_req;
					mem_busy   = 1'b0;
				end else begin
					mem_wait = mem_wait - 3'd1;
				end
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	a_toggle_per_word: assert property (@(posedge clk_sys) disable iff (RESET)
		(rom_wr_req != req_d) == took)
		else begin
			$display("FAIL rom_wr_req toggle %h transfer %h", $sampled(rom_wr_req != req_d),
				$sampled(took));
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	a_rom_addr: assert property (@(posedge clk_sys) disable iff (RESET)
		took |-> rom_addr == exp_addr)
		else begin
			$display("FAIL rom_addr %h expected %h", $sampled(rom_addr), $sampled(exp_addr));
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	a_rom_wdata: assert property (@(posedge clk_sys) disable iff (RESET)
		took |-> rom_wdata == exp_wdata)
		else begin
			$display("FAIL rom_wdata %h expected %h", $sampled(rom_wdata), $sampled(exp_wdata));
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	a_ready_low: assert property (@(posedge clk_sys) disable iff (RESET)
		(rom_wr_req != rom_wr_ack) |-> !dl_ready)
		else begin
			$display("dl_ready was high with a ROM write outstanding");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	a_rom_size: assert property (@(posedge clk_sys) disable iff (RESET)
		size_chk |-> rom_size == last_size)
		else begin
			$display("FAIL rom_size %h expected %h", $sampled(rom_size), $sampled(last_size));
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	a_region: assert property (@(posedge clk_sys) disable iff (RESET)
		region_chk |-> region_set && region == exp_region)
		else begin
			$display("FAIL region %h expected %h", $sampled(region), $sampled(exp_region));
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	a_no_auto: assert property (@(posedge clk_sys) disable iff (RESET)
		(!region_auto && dl_active) |-> !region_set)
		else begin
			$display("FAIL region_set %h expected 0", $sampled(region_set));
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	a_quirks: assert property (@(posedge clk_sys) disable iff (RESET)
		quirk_chk |-> quirks == exp_q)
		else begin
			$display("FAIL quirks %h expected %h", $sampled(quirks), $sampled(exp_q));
			$display("Simulation finished: FAIL");
			$fatal(1);
		end

	//////////////////////////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////////////////////////

	// ID at 'h183..'h18A, letters at 'h1F0..'h1F3, filler from the whole address
	function automatic logic [7:0] cart_byte(input logic [ADDR_W-1:0] a, input logic [63:0] id,
		input logic [31:0] letters);
		if (a >= 25'h183 && a <= 25'h18A) begin
			return id[8*(32'h18A - 32'(a)) +: 8];
		end else if (a >= 25'h1F0 && a <= 25'h1F3) begin
			return letters[8*(32'h1F3 - 32'(a)) +: 8];
		end
		return a[7:0] ^ a[15:8] ^ a[23:16] ^ {7'd0, a[24]} ^ 8'h5A;
	endfunction

	task automatic send_word(input logic [ADDR_W-1:0] a, input logic [63:0] id,
		input logic [31:0] letters);
		int n;
		if (take_bits(2) == 0) begin
			dl_valid = 1'b0;
			repeat (int'(take_bits(2)) + 1) @(negedge clk_sys);
		end
		dl_addr  = a;
		dl_data  = {cart_byte(a + 25'd1, id, letters), cart_byte(a, id, letters)};
		dl_valid = 1'b1;
		n = 0;
		do begin
			@(negedge clk_sys);
			n++;
			if (n > WAIT_LIMIT) begin
				stop_failed("download word was never accepted");
			end
		end while (!took);
	endtask

	task automatic load_cart(input logic [63:0] id, input logic [31:0] letters,
		input logic auto, input region_order_t ord);
		region_auto  = auto;
		region_order = ord;
		dl_active    = 1'b1;
		repeat (3) @(negedge clk_sys);
		// New load must have cleared the previous quirks
		exp_q     = '0;
		quirk_chk = 1'b1;
		@(negedge clk_sys);
		quirk_chk = 1'b0;
		for (int unsigned w = 0; w <= 32'h204; w += 2) begin
			send_word(ADDR_W'(w), id, letters);
		end
		dl_valid = 1'b0;
		wait_write_done();
		if (auto) begin
			wait_region_set();
			exp_region = expected_region(letters, ord);
			region_chk = 1'b1;
			region_checks++;
		end
		exp_q     = expected_quirks(id);
		quirk_chk = 1'b1;
		quirk_checks++;
		@(negedge clk_sys);
		region_chk = 1'b0;
		quirk_chk  = 1'b0;
		dl_active  = 1'b0;
		repeat (3) @(negedge clk_sys);
		size_chk = 1'b1;
		@(negedge clk_sys);
		size_chk = 1'b0;
		repeat (6) @(negedge clk_sys);
	endtask

	initial begin
		RESET        = 1'b1;
		dl_active    = 1'b0;
		dl_valid     = 1'b0;
		dl_addr      = '0;
		dl_data      = '0;
		rom_wr_ack   = 1'b0;
		region_auto  = 1'b0;
		region_order = ORDER_US_EU_JP;
		repeat (5) @(negedge clk_sys);
		RESET = 1'b0;
		@(negedge clk_sys);

		load_cart("T-081276", "JUE ", 1'b1, ORDER_US_EU_JP);
		load_cart("T-68123-", "E   ", 1'b1, ORDER_JP_US_EU);
		load_cart("UNKNOWN ", "    ", 1'b1, ORDER_EU_US_JP);
		// Byte 'h1F3 carries a U that must be ignored
		load_cart("MK-1229 ", "J  U", 1'b1, ORDER_US_JP_EU);
		load_cart("T-35036 ", "U   ", 1'b0, ORDER_EU_US_JP);
		load_cart("T-89016 ", "1   ", 1'b1, ORDER_JP_US_EU);
		load_cart("G-4060  ", "JU  ", 1'b1, ORDER_EU_US_JP);

		if (region_checks == 6 && quirk_checks == 7) begin
			$display("Simulation finished: PASS");
			$finish;
		end else begin
			$display("Not every check was reached");
			$display("Simulation finished: FAIL");
			$fatal(1);
		end
	end

endmodule

`default_nettype wire

/* cart_loader.f */
+incdir+bench
logic/cart_pkg.sv
logic/download_port.sv
logic/header_region_scan.sv
logic/region_select.sv
logic/quirk_match.sv
logic/cart_loader.sv
bench/cart_loader_tb.sv

/* logic/cart_loader.sv */
// Cartridge loader top: download port, header region scan, region choice and quirk lookup
`timescale 1ns/1ps
`default_nettype none

module cart_loader
	import cart_pkg::*;
(
	input  wire logic                   clk_sys,
	input  wire logic                   RESET,

	input  wire logic                   dl_active,
	input  wire logic                   dl_valid,
	output logic                        dl_ready,
	input  wire logic [ADDR_W-1:0]      dl_addr,
	input  wire logic [DATA_W-1:0]      dl_data,

	output logic      [ADDR_W-2:0]      rom_addr,
	output logic      [DATA_W-1:0]      rom_wdata,
	output logic                        rom_wr_req,
	input  wire logic                   rom_wr_ack,
	output logic      [ADDR_W-1:0]      rom_size,

	input  wire logic                   region_auto,
	input  wire region_order_t          region_order,
	output region_t                     region,
	output logic                        region_set,
	output logic      [QUIRK_COUNT-1:0] quirks
);

	logic word_take;
	logic load_start;
	logic load_end;
	logic hdr_j;
	logic hdr_u;
	logic hdr_e;
	logic hdr_ready;

	download_port u_download_port (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.dl_active  (dl_active),
		.dl_valid   (dl_valid),
		.dl_ready   (dl_ready),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.rom_addr   (rom_addr),
		.rom_wdata  (rom_wdata),
		.rom_wr_req (rom_wr_req),
		.rom_wr_ack (rom_wr_ack),
		.rom_size   (rom_size),
		.word_take  (word_take),
		.load_start (load_start),
		.load_end   (load_end)
	);

	// Header watchers see the same accepted words as the ROM
	header_region_scan u_header_region_scan (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.word_take  (word_take),
		.load_start (load_start),
		.load_end   (load_end),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.hdr_j      (hdr_j),
		.hdr_u      (hdr_u),
		.hdr_e      (hdr_e),
		.hdr_ready  (hdr_ready)
	);

	region_select u_region_select (
		.clk_sys      (clk_sys),
		.RESET        (RESET),
		.hdr_j        (hdr_j),
		.hdr_u        (hdr_u),
		.hdr_e        (hdr_e),
		.hdr_ready    (hdr_ready),
		.region_auto  (region_auto),
		.region_order (region_order),
		.region       (region),
		.region_set   (region_set)
	);

	quirk_match u_quirk_match (
		.clk_sys    (clk_sys),
		.RESET      (RESET),
		.word_take  (word_take),
		.load_start (load_start),
		.dl_addr    (dl_addr),
		.dl_data    (dl_data),
		.quirks     (quirks)
	);

endmodule

`default_nettype wire

/* logic/cart_pkg.sv */
// Shared types, header address constants and the quirk ID table for the cartridge loader
`default_nettype none

package cart_pkg;

	//////////////////////////////////////////////////////////////////////
	// Download bus widths
	//////////////////////////////////////////////////////////////////////

	localparam int unsigned ADDR_W = 25;
	localparam int unsigned DATA_W = 16;

	//////////////////////////////////////////////////////////////////////
	// Cartridge header layout (byte addresses, words start on even ones)
	//////////////////////////////////////////////////////////////////////

	// Product ID occupies bytes 'h183 to 'h18A
	localparam logic [ADDR_W-1:0] ADDR_ID_LAST  = 25'h18A;
	localparam logic [ADDR_W-1:0] ADDR_ID_CHECK = 25'h18C;

	// Region letters
	localparam logic [ADDR_W-1:0] ADDR_REGION_A = 25'h1F0;
	localparam logic [ADDR_W-1:0] ADDR_REGION_B = 25'h1F2;

	localparam logic [ADDR_W-1:0] ADDR_HDR_END  = 25'h200;

	// Console regions, code 3 unused
	typedef enum logic [1:0] {
		JP = 2'd0,
		US = 2'd1,
		EU = 2'd2
	} region_t;

	// Auto region priority, highest first
	typedef enum logic [1:0] {
		ORDER_US_EU_JP = 2'd0,
		ORDER_EU_US_JP = 2'd1,
		ORDER_US_JP_EU = 2'd2,
		ORDER_JP_US_EU = 2'd3
	} region_order_t;

	//////////////////////////////////////////////////////////////////////
	// Compatibility quirks
	//////////////////////////////////////////////////////////////////////

	// Bit positions in the quirk flag vector
	typedef enum logic [2:0] {
		SRAM, EEPROM, NORAM, FIFO, PIER, SVP, FMBUSY, SCHAN
	} quirk_t;

	localparam int unsigned QUIRK_COUNT     = 8;
	localparam int unsigned QUIRK_TABLE_LEN = 10;

	// ASCII product IDs, '?' matches any byte
	localparam logic [63:0] QUIRK_ID [QUIRK_TABLE_LEN] = '{
		"T-081276", "T-81406 ", "MK-1215 ", "G-4060  ", "T-113016",
		"T-89016 ", "T-574023", "MK-1229 ", "T-35036 ", "T-68???-"
	};

	localparam quirk_t QUIRK_KIND [QUIRK_TABLE_LEN] = '{
		SRAM, SRAM, EEPROM, EEPROM, NORAM,
		FIFO, PIER, SVP, FMBUSY, SCHAN
	};

endpackage

`default_nettype wire

/* logic/download_port.sv */
// Download front end: takes host words with valid/ready and issues toggle-handshake ROM writes
`timescale 1ns/1ps
`default_nettype none

module download_port
	import cart_pkg::*;
(
	input  wire logic              clk_sys,
	input  wire logic              RESET,

	// Host download channel
	input  wire logic              dl_active,
	input  wire logic              dl_valid,
	output logic                   dl_ready,
	input  wire logic [ADDR_W-1:0] dl_addr,
	input  wire logic [DATA_W-1:0] dl_data,

	// ROM write port
	output logic      [ADDR_W-2:0] rom_addr,
	output logic      [DATA_W-1:0] rom_wdata,
	output logic                   rom_wr_req,
	input  wire logic              rom_wr_ack,

	output logic      [ADDR_W-1:0] rom_size,
	output logic                   word_take,
	output logic                   load_start,
	output logic                   load_end
);

	logic active_d;

	// No write in flight when request and ack agree
	assign dl_ready  = (rom_wr_req == rom_wr_ack);
	assign word_take = dl_valid & dl_ready;

	//////////////////////////////////////////////////////////////////////
	// ROM write issue
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			rom_wr_req <= 1'b0;
		end else if (word_take) begin
			rom_wr_req <= ~rom_wr_req;
		end
	end

	// Memory wants the even byte in the high half
	always_ff @(posedge clk_sys) begin
		if (word_take) begin
			rom_addr  <= dl_addr[ADDR_W-1:1];
			rom_wdata <= {dl_data[7:0], dl_data[15:8]};
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Load framing and ROM size
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			active_d   <= 1'b0;
			load_start <= 1'b0;
			load_end   <= 1'b0;
		end else begin
			active_d   <= dl_active;
			load_start <= dl_active & ~active_d;
			load_end   <= ~dl_active & active_d;
		end
	end

	// Last word written is still held in rom_addr
	always_ff @(posedge clk_sys) begin
		if (active_d && !dl_active) begin
			rom_size <= {rom_addr, 1'b0};
		end
	end

	// One write at a time, whatever the memory latency
	a_single_outstanding: assert property (@(posedge clk_sys) disable iff (RESET)
		(rom_wr_req != rom_wr_ack) |=> $stable(rom_wr_req))
		else $error("ROM request toggled with a write outstanding");

endmodule

`default_nettype wire

/* logic/header_region_scan.sv */
// Scans the cartridge header for region letters and flags when the header has been loaded
`timescale 1ns/1ps
`default_nettype none

module header_region_scan
	import cart_pkg::*;
(
	input  wire logic              clk_sys,
	input  wire logic              RESET,
	input  wire logic              word_take,
	input  wire logic              load_start,
	input  wire logic              load_end,
	input  wire logic [ADDR_W-1:0] dl_addr,
	input  wire logic [DATA_W-1:0] dl_data,
	output logic                   hdr_j,
	output logic                   hdr_u,
	output logic                   hdr_e,
	output logic                   hdr_ready
);

	logic [2:0] cls_lo;
	logic [2:0] cls_hi;
	logic [2:0] hit;
	logic       in_load;

	// {J, U, other} for one header byte
	function automatic logic [2:0] classify(input logic [7:0] ch);
		logic [2:0] res;
		res = 3'b000;
		if (ch == "J") begin
			res = 3'b100;
		end else if (ch == "U") begin
			res = 3'b010;
		end else if (ch >= "0" && ch <= "Z") begin
			res = 3'b001;
		end
		return res;
	endfunction

	assign cls_lo = classify(dl_data[7:0]);
	assign cls_hi = classify(dl_data[15:8]);

	// Bytes 'h1F0 and 'h1F1 from word A, only 'h1F2 from word B
	always_comb begin
		hit = 3'b000;
		if (word_take && dl_addr == ADDR_REGION_A) begin
			hit = cls_lo | cls_hi;
		end else if (word_take && dl_addr == ADDR_REGION_B) begin
			hit = cls_lo;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || load_start) begin
			{hdr_j, hdr_u, hdr_e} <= 3'b000;
		end else begin
			{hdr_j, hdr_u, hdr_e} <= {hdr_j, hdr_u, hdr_e} | hit;
		end
	end

	// Header complete
	always_ff @(posedge clk_sys) begin
		if (RESET || load_end) begin
			hdr_ready <= 1'b0;
		end else if (word_take && dl_addr == ADDR_HDR_END) begin
			hdr_ready <= 1'b1;
		end
	end

	// Open from the start pulse up to the end pulse
	always_ff @(posedge clk_sys) begin
		if (RESET || load_end) begin
			in_load <= 1'b0;
		end else if (load_start) begin
			in_load <= 1'b1;
		end
	end

	// Ready never outlives the load
	a_ready_ends: assert property (@(posedge clk_sys) disable iff (RESET)
		hdr_ready |-> in_load)
		else $error("hdr_ready high outside a load");

endmodule

`default_nettype wire

/* logic/quirk_match.sv */
// Collects the cartridge product ID and flags any compatibility quirk listed for it
`timescale 1ns/1ps
`default_nettype none

module quirk_match
	import cart_pkg::*;
(
	input  wire logic                   clk_sys,
	input  wire logic                   RESET,
	input  wire logic                   word_take,
	input  wire logic                   load_start,
	input  wire logic [ADDR_W-1:0]      dl_addr,
	input  wire logic [DATA_W-1:0]      dl_data,
	output logic      [QUIRK_COUNT-1:0] quirks
);

	logic [63:0]       cart_id;
	logic              hit;
	quirk_t            hit_kind;

	// Entry byte '?' accepts anything
	function automatic logic id_match(input logic [63:0] entry, input logic [63:0] id);
		logic ok;
		ok = 1'b1;
		for (int b = 0; b < 8; b++) begin
			if (entry[8*b +: 8] != "?" && entry[8*b +: 8] != id[8*b +: 8]) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// ID capture, first byte in the upper end
	//////////////////////////////////////////////////////////////////////

	// Word eight below the last ID byte holds byte 'h183 in its odd half
	always_ff @(posedge clk_sys) begin
		if (word_take) begin
			if (dl_addr == ADDR_ID_LAST - ADDR_W'(8)) begin
				cart_id <= {cart_id[55:0], dl_data[15:8]};
			end else if (dl_addr > ADDR_ID_LAST - ADDR_W'(8) && dl_addr < ADDR_ID_LAST) begin
				cart_id <= {cart_id[47:0], dl_data[7:0], dl_data[15:8]};
			end else if (dl_addr == ADDR_ID_LAST) begin
				cart_id <= {cart_id[55:0], dl_data[7:0]};
			end
		end
	end

	// Walk backwards so the earliest entry wins
	always_comb begin
		hit      = 1'b0;
		hit_kind = SRAM;
		for (int e = QUIRK_TABLE_LEN - 1; e >= 0; e--) begin
			if (id_match(QUIRK_ID[e], cart_id)) begin
				hit      = 1'b1;
				hit_kind = QUIRK_KIND[e];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (RESET || load_start) begin
			quirks <= '0;
		end else if (word_take && dl_addr == ADDR_ID_CHECK) begin
			quirks <= '0;
			if (hit) begin
				quirks[hit_kind] <= 1'b1;
			end
		end
	end

	a_one_quirk: assert property (@(posedge clk_sys) disable iff (RESET)
		$onehot0(quirks))
		else $error("more than one quirk flag set");

endmodule

`default_nettype wire

/* logic/region_select.sv */
// Picks the console region from the header flags and the configured priority order
`timescale 1ns/1ps
`default_nettype none

module region_select
	import cart_pkg::*;
(
	input  wire logic          clk_sys,
	input  wire logic          RESET,
	input  wire logic          hdr_j,
	input  wire logic          hdr_u,
	input  wire logic          hdr_e,
	input  wire logic          hdr_ready,
	input  wire logic          region_auto,
	input  wire region_order_t region_order,
	output region_t            region,
	output logic               region_set
);

	logic    ready_d;
	region_t pick;

	// First flagged region in the order, else the order's head
	always_comb begin
		case (region_order)
			ORDER_US_EU_JP: pick = hdr_u ? US : hdr_e ? EU : hdr_j ? JP : US;
			ORDER_EU_US_JP: pick = hdr_e ? EU : hdr_u ? US : hdr_j ? JP : EU;
			ORDER_US_JP_EU: pick = hdr_u ? US : hdr_j ? JP : hdr_e ? EU : US;
			ORDER_JP_US_EU: pick = hdr_j ? JP : hdr_u ? US : hdr_e ? EU : JP;
			default:        pick = US;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Region strobe on header ready edges
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			ready_d    <= 1'b0;
			region_set <= 1'b0;
			region     <= JP;
		end else begin
			ready_d <= hdr_ready;
			if (hdr_ready && !ready_d && region_auto) begin
				region     <= pick;
				region_set <= 1'b1;
			end else if (!hdr_ready && ready_d) begin
				region_set <= 1'b0;
			end
		end
	end

	a_region_legal: assert property (@(posedge clk_sys) disable iff (RESET)
		region inside {JP, US, EU})
		else $error("region took the unused code");

endmodule

`default_nettype wire
